/* verilog/csi2_macros.svh */
`ifndef CSI2_MACROS_SVH
`define CSI2_MACROS_SVH

// stream word and header ECC.
`define CSI2_WORD_W       32
`define CSI2_SYN_W        6
`define CSI2_POS_W        5
`define CSI2_POS_NONE     31

// header field widths.
`define CSI2_RSVD_W       2
`define CSI2_WC_W         16
`define CSI2_VC_W         2
`define CSI2_DT_W         6

`define CSI2_SHORT_DT_MAX 6'h10
`define CSI2_CNT_W        16

`endif

/* verilog/csi2_hdr_pkg.sv */
`include "csi2_macros.svh"

package csi2_hdr_pkg;

  // bits covered by the ECC, below the ecc field.
  localparam int HDR_DATA_W = `CSI2_WORD_W - `CSI2_RSVD_W - `CSI2_SYN_W;

  typedef struct packed {
    logic [`CSI2_RSVD_W-1:0] rsvd;
    logic [`CSI2_SYN_W-1:0]  ecc;
    logic [`CSI2_WC_W-1:0]   wc;
    logic [`CSI2_VC_W-1:0]   vc;
    logic [`CSI2_DT_W-1:0]   dt;
  } csi2_hdr_fields_t;

  typedef union packed {
    logic [`CSI2_WORD_W-1:0] raw;
    csi2_hdr_fields_t        fields;
  } csi2_hdr_u;

  // one row per parity bit, each bit picks a header bit for that parity.
  localparam logic [`CSI2_SYN_W-1:0][HDR_DATA_W-1:0] ECC_MASK = {
    24'hEFFC00,  // p5.
    24'hDF03F0,  // p4.
    24'hB8E38E,  // p3.
    24'h749A6D,  // p2.
    24'hF2555B,  // p1.
    24'hF12CB7   // p0.
  };

endpackage

/* verilog/csi2_rx_pkg.sv */
`include "csi2_macros.svh"

package csi2_rx_pkg;

  typedef struct packed {
    logic [`CSI2_VC_W-1:0] vc;
    logic [`CSI2_DT_W-1:0] dt;
    logic [`CSI2_WC_W-1:0] wc;
    logic                  repaired;  // header needed a single-bit fix.
  } csi2_pkt_info_t;

  typedef struct packed {
    logic [`CSI2_WORD_W-1:0] data;
    logic                    last;
  } csi2_beat_t;

  // both counters stick at all ones.
  typedef struct packed {
    logic [`CSI2_CNT_W-1:0] repaired_cnt;
    logic [`CSI2_CNT_W-1:0] dropped_cnt;
  } csi2_stat_t;

endpackage

/* verilog/csi2_syndrome_rom.sv */
`timescale 1ns/10ps
`include "csi2_macros.svh"

module csi2_syndrome_rom
(
  input                           clk_i,
  input                           srst_i,
  input        [`CSI2_SYN_W-1:0]  syndrome_i,
  output logic [`CSI2_POS_W-1:0]  err_pos_o
);

  import csi2_hdr_pkg::*;

  localparam int ROM_DEPTH = 1 << `CSI2_SYN_W;

  typedef logic [`CSI2_POS_W-1:0] pos_t;
  typedef logic [ROM_DEPTH-1:0][`CSI2_POS_W-1:0] rom_t;

  localparam pos_t POS_NONE = `CSI2_POS_NONE;

  function automatic rom_t build_rom();
    rom_t                   tbl;
    logic [`CSI2_SYN_W-1:0] col;
    for (int s = 0; s < ROM_DEPTH; s++)
    begin
      tbl[s] = POS_NONE;
    end
    // the mask column of a data bit is its syndrome.
    for (int k = 0; k < HDR_DATA_W; k++)
    begin
      for (int j = 0; j < `CSI2_SYN_W; j++)
      begin
        col[j] = ECC_MASK[j][k];
      end
      tbl[col] = pos_t'(k);
    end
    for (int j = 0; j < `CSI2_SYN_W; j++)
    begin
      tbl[1 << j] = pos_t'(HDR_DATA_W + j);  // parity bit hit.
    end
    return tbl;
  endfunction

  localparam rom_t ROM = build_rom();

  always_ff @(posedge clk_i, posedge srst_i)
  begin
    if (srst_i)
      err_pos_o <= POS_NONE;
    else
      err_pos_o <= ROM[syndrome_i];
  end

endmodule

/* verilog/csi2_hamming_dec.sv */
`timescale 1ns/10ps
`include "csi2_macros.svh"

module csi2_hamming_dec
(
  input                              clk_i,
  input                              srst_i,
  input                              valid_i,
  input        [`CSI2_WORD_W-1:0]    data_i,
  input                              pkt_done_i,
  output logic                       valid_o,
  output csi2_hdr_pkg::csi2_hdr_u    data_o,
  output logic                       error_o,
  output logic                       error_corrected_o
);

  import csi2_hdr_pkg::*;

  localparam logic [`CSI2_POS_W-1:0] POS_NONE = `CSI2_POS_NONE;

  logic [`CSI2_SYN_W-1:0]  parity;
  logic [`CSI2_SYN_W-1:0]  syndrome;
  logic [`CSI2_POS_W-1:0]  err_pos;
  logic [`CSI2_WORD_W-1:0] flip_mask;
  csi2_hdr_u               data_d;
  logic                    valid_d;
  logic                    syn_nz_d;
  logic                    hdr_passed;
  logic                    hdr_valid;
  logic                    hdr_err;
  logic                    hdr_fix;

  always_comb
  begin
    for (int j = 0; j < `CSI2_SYN_W; j++)
    begin
      parity[j] = ^(data_i[HDR_DATA_W-1:0] & ECC_MASK[j]);
    end
  end

  assign syndrome = parity ^ data_i[HDR_DATA_W +: `CSI2_SYN_W];

  // position is ready at stage 2, next to data_d.
  csi2_syndrome_rom u_rom
  (
    .clk_i      ( clk_i    ),
    .srst_i     ( srst_i   ),
    .syndrome_i ( syndrome ),
    .err_pos_o  ( err_pos  )
  );

  // first valid word after pkt_done is the header.
  assign hdr_valid = valid_d && !hdr_passed && !pkt_done_i;
  assign hdr_err   = hdr_valid && syn_nz_d;
  assign hdr_fix   = hdr_err && (err_pos != POS_NONE);

  // parity-bit positions leave the word as it is.
  assign flip_mask = (err_pos < HDR_DATA_W) ?
                     ({{(`CSI2_WORD_W-1){1'b0}}, 1'b1} << err_pos) : '0;

  always_ff @(posedge clk_i, posedge srst_i)
  begin
    if (srst_i)
    begin
      valid_d    <= 1'b0;
      syn_nz_d   <= 1'b0;
      hdr_passed <= 1'b0;
    end
    else if (pkt_done_i)
    begin
      valid_d    <= 1'b0;
      syn_nz_d   <= 1'b0;
      hdr_passed <= 1'b0;
    end
    else
    begin
      valid_d  <= valid_i;
      syn_nz_d <= (syndrome != '0);
      if (hdr_valid)
        hdr_passed <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    data_d.raw <= data_i;
  end

  always_ff @(posedge clk_i, posedge srst_i)
  begin
    if (srst_i)
    begin
      valid_o           <= 1'b0;
      error_o           <= 1'b0;
      error_corrected_o <= 1'b0;
    end
    else if (pkt_done_i)
    begin
      valid_o           <= 1'b0;
      error_o           <= 1'b0;
      error_corrected_o <= 1'b0;
    end
    else
    begin
      valid_o <= valid_d;
      if (hdr_err)
        error_o <= 1'b1;  // held until pkt_done.
      if (hdr_fix)
        error_corrected_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (hdr_fix)
      data_o.raw <= data_d.raw ^ flip_mask;
    else
      data_o.raw <= data_d.raw;
  end

endmodule

/* verilog/csi2_pkt_framer.sv */
`timescale 1ns/10ps
`include "csi2_macros.svh"

module csi2_pkt_framer
(
  input                                  clk_i,
  input                                  srst_i,
  input                                  dec_valid_i,
  input  csi2_hdr_pkg::csi2_hdr_u        dec_data_i,
  input                                  dec_error_i,
  input                                  dec_corrected_i,
  output logic                           pkt_done_o,
  output logic                           hdr_valid_o,
  output csi2_rx_pkg::csi2_pkt_info_t    hdr_o,
  output logic                           drop_o,
  output logic                           payload_valid_o,
  output csi2_rx_pkg::csi2_beat_t        payload_o,
  output csi2_rx_pkg::csi2_stat_t        stat_o
);

  import csi2_rx_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PAYLOAD,
    ST_DROP,
    ST_CLEAR
  } state_t;

  // one stale decoder cycle plus two flushed ones.
  localparam logic [`CSI2_WC_W-2:0] FLUSH_CNT = 3;

  state_t                state;
  logic [`CSI2_WC_W-2:0] cnt_q;
  logic [`CSI2_WC_W:0]   wc_round;
  logic [`CSI2_WC_W-2:0] hdr_beats;
  logic                  hdr_bad;
  csi2_pkt_info_t        hdr_info;

  assign hdr_info.vc       = dec_data_i.fields.vc;
  assign hdr_info.dt       = dec_data_i.fields.dt;
  assign hdr_info.wc       = dec_data_i.fields.wc;
  assign hdr_info.repaired = dec_corrected_i;

  // word count in bytes, four bytes per beat.
  assign wc_round  = {1'b0, dec_data_i.fields.wc} + 3'd3;
  assign hdr_beats = (dec_data_i.fields.dt < `CSI2_SHORT_DT_MAX) ? '0 : wc_round[`CSI2_WC_W:2];
  assign hdr_bad   = dec_error_i && !dec_corrected_i;

  always_ff @(posedge clk_i, posedge srst_i)
  begin
    if (srst_i)
    begin
      state           <= ST_IDLE;
      cnt_q           <= '0;
      pkt_done_o      <= 1'b0;
      hdr_valid_o     <= 1'b0;
      drop_o          <= 1'b0;
      payload_valid_o <= 1'b0;
      stat_o          <= '0;
    end
    else
    begin
      pkt_done_o      <= 1'b0;
      hdr_valid_o     <= 1'b0;
      drop_o          <= 1'b0;
      payload_valid_o <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (dec_valid_i && hdr_bad)
          begin
            drop_o     <= 1'b1;
            pkt_done_o <= 1'b1;
            cnt_q      <= FLUSH_CNT;
            state      <= ST_DROP;
            if (stat_o.dropped_cnt != '1)
              stat_o.dropped_cnt <= stat_o.dropped_cnt + 1'b1;
          end
          else if (dec_valid_i)
          begin
            hdr_valid_o <= 1'b1;
            if (dec_corrected_i && stat_o.repaired_cnt != '1)
              stat_o.repaired_cnt <= stat_o.repaired_cnt + 1'b1;
            if (hdr_beats == '0)
              pkt_done_o <= 1'b1;  // short packet.
            else
            begin
              cnt_q <= hdr_beats;
              state <= ST_PAYLOAD;
            end
          end
        end
        ST_PAYLOAD:
        begin
          if (dec_valid_i)
          begin
            payload_valid_o <= 1'b1;
            cnt_q           <= cnt_q - 1'b1;
            if (cnt_q == 1)
            begin
              pkt_done_o <= 1'b1;
              state      <= ST_IDLE;
            end
          end
        end
        ST_DROP:
        begin
          if (cnt_q != '0)
            cnt_q <= cnt_q - 1'b1;
          else if (dec_valid_i)
            state <= ST_CLEAR;  // rest of the payload re-armed the decoder.
          else
            state <= ST_IDLE;
        end
        ST_CLEAR:
        begin
          if (!dec_valid_i)
          begin
            pkt_done_o <= 1'b1;
            state      <= ST_IDLE;
          end
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    hdr_o          <= hdr_info;
    payload_o.data <= dec_data_i.raw;
    payload_o.last <= (cnt_q == 1);
  end

endmodule

/* verilog/csi2_rx_top.sv */
`timescale 1ns/10ps
`include "csi2_macros.svh"

module csi2_rx_top
(
  input                                  clk_i,
  input                                  srst_i,
  input                                  valid_i,
  input        [`CSI2_WORD_W-1:0]        data_i,
  output logic                           hdr_valid_o,
  output csi2_rx_pkg::csi2_pkt_info_t    hdr_o,
  output logic                           drop_o,
  output logic                           payload_valid_o,
  output csi2_rx_pkg::csi2_beat_t        payload_o,
  output csi2_rx_pkg::csi2_stat_t        stat_o
);

  import csi2_hdr_pkg::*;

  logic      dec_valid;
  csi2_hdr_u dec_data;
  logic      dec_error;
  logic      dec_corrected;
  logic      pkt_done;

  csi2_hamming_dec u_dec
  (
    .clk_i             ( clk_i         ),
    .srst_i            ( srst_i        ),
    .valid_i           ( valid_i       ),
    .data_i            ( data_i        ),
    .pkt_done_i        ( pkt_done      ),
    .valid_o           ( dec_valid     ),
    .data_o            ( dec_data      ),
    .error_o           ( dec_error     ),
    .error_corrected_o ( dec_corrected )
  );

  csi2_pkt_framer u_framer
  (
    .clk_i           ( clk_i           ),
    .srst_i          ( srst_i          ),
    .dec_valid_i     ( dec_valid       ),
    .dec_data_i      ( dec_data        ),
    .dec_error_i     ( dec_error       ),
    .dec_corrected_i ( dec_corrected   ),
    .pkt_done_o      ( pkt_done        ),
    .hdr_valid_o     ( hdr_valid_o     ),
    .hdr_o           ( hdr_o           ),
    .drop_o          ( drop_o          ),
    .payload_valid_o ( payload_valid_o ),
    .payload_o       ( payload_o       ),
    .stat_o          ( stat_o          )
  );

endmodule

/* sim/tb_csi2_checks.svh */
`ifndef TB_CSI2_CHECKS_SVH
`define TB_CSI2_CHECKS_SVH

csi2_pkt_info_t hdr_q[$];
time            hdr_t_q[$];  // negedge where each header is due.
csi2_beat_t     beat_q[$];
time            drop_t_q[$];

int hdr_errs   = 0;
int beat_errs  = 0;
int drop_errs  = 0;
int stat_errs  = 0;
int other_errs = 0;

task automatic check_hdr(input csi2_pkt_info_t got);
  csi2_pkt_info_t exp_info;
  time            exp_t;
  if (hdr_q.size() == 0)
  begin
    $display("error at %t: header vc %0d dt 0x%02h wc 0x%04h came with none expected",
             $time, got.vc, got.dt, got.wc);
    hdr_errs++;
    return;
  end
  exp_info = hdr_q.pop_front();
  exp_t    = hdr_t_q.pop_front();
  if (got !== exp_info)
  begin
    $display("error at %t: header got vc %0d dt 0x%02h wc 0x%04h rep %0b", $time,
             got.vc, got.dt, got.wc, got.repaired);
    $display("error at %t: header exp vc %0d dt 0x%02h wc 0x%04h rep %0b", $time,
             exp_info.vc, exp_info.dt, exp_info.wc, exp_info.repaired);
    hdr_errs++;
  end
  if ($time != exp_t)
  begin
    $display("error at %t: header latency wrong, it was due at %t", $time, exp_t);
    hdr_errs++;
  end
endtask

task automatic check_beat(input csi2_beat_t got);
  csi2_beat_t exp_beat;
  if (beat_q.size() == 0)
  begin
    $display("error at %t: payload beat 0x%08h came with none expected", $time, got.data);
    beat_errs++;
    return;
  end
  exp_beat = beat_q.pop_front();
  if (got !== exp_beat)
  begin
    $display("error at %t: beat got 0x%08h last %0b, exp 0x%08h last %0b", $time,
             got.data, got.last, exp_beat.data, exp_beat.last);
    beat_errs++;
  end
endtask

task automatic check_drop();
  time exp_t;
  if (drop_t_q.size() == 0)
  begin
    $display("error at %t: drop pulse with no dropped packet expected", $time);
    drop_errs++;
    return;
  end
  exp_t = drop_t_q.pop_front();
  if ($time != exp_t)
  begin
    $display("error at %t: drop pulse off time, it was due at %t", $time, exp_t);
    drop_errs++;
  end
endtask

task automatic check_stat(input csi2_stat_t got, input csi2_stat_t exp_stat);
  if (got !== exp_stat)
  begin
    $display("error at %t: stat got repaired %0d dropped %0d, exp repaired %0d dropped %0d",
             $time, got.repaired_cnt, got.dropped_cnt,
             exp_stat.repaired_cnt, exp_stat.dropped_cnt);
    stat_errs++;
  end
endtask

`endif

/* sim/tb_csi2_rx.sv */
`timescale 1ns/10ps
`include "csi2_macros.svh"

module tb_csi2_rx;

  import csi2_hdr_pkg::*;
  import csi2_rx_pkg::*;

  localparam time         CLK_PERIOD = 100;
  localparam time         DRIVE_DLY  = 10;
  localparam int          RST_CYCLES = 8;
  localparam int          GAP_CYCLES = 4;
  localparam int          ROW_W      = 6;  // words per packet in the input file.
  localparam int          MAX_PKTS   = 32;
  localparam logic [31:0] LCG_SEED   = 32'd7269;

  logic                    clk = 1'b0;
  logic                    srst;
  logic                    valid;
  logic [`CSI2_WORD_W-1:0] data;
  logic                    hdr_valid;
  csi2_pkt_info_t          hdr;
  logic                    drop;
  logic                    payload_valid;
  csi2_beat_t              payload;
  csi2_stat_t              stat;

  logic [31:0] rows [0:ROW_W*MAX_PKTS-1];
  logic [31:0] lcg_state = LCG_SEED;
  int          n_pkts;
  csi2_stat_t  exp_stat;
  time         wd_limit;
  logic        wd_armed = 1'b0;

  `include "tb_csi2_checks.svh"

  csi2_rx_top u_csi2_rx_top
  (
    .clk_i           ( clk           ),
    .srst_i          ( srst          ),
    .valid_i         ( valid         ),
    .data_i          ( data          ),
    .hdr_valid_o     ( hdr_valid     ),
    .hdr_o           ( hdr           ),
    .drop_o          ( drop          ),
    .payload_valid_o ( payload_valid ),
    .payload_o       ( payload       ),
    .stat_o          ( stat          )
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [`CSI2_SYN_W-1:0] syndrome_of(input logic [31:0] raw);
    logic [`CSI2_SYN_W-1:0] par;
    for (int j = 0; j < `CSI2_SYN_W; j++)
    begin
      par[j] = ^(raw[HDR_DATA_W-1:0] & ECC_MASK[j]);
    end
    return par ^ raw[HDR_DATA_W +: `CSI2_SYN_W];
  endfunction

  task automatic drive_word(input logic v, input logic [31:0] w, output time t_edge);
    @(posedge clk);
    t_edge = $time;
    #(DRIVE_DLY);
    valid = v;
    data  = w;
  endtask

  task automatic send_packet(input int p);
    logic [31:0]    raw;
    int             nsend;
    int             cls;
    int             nbeats;
    csi2_pkt_info_t info;
    csi2_beat_t     beat;
    time            t_edge;
    raw           = rows[p*ROW_W];
    nsend         = rows[p*ROW_W+1];
    info.vc       = rows[p*ROW_W+2][`CSI2_VC_W-1:0];
    info.dt       = rows[p*ROW_W+3][`CSI2_DT_W-1:0];
    info.wc       = rows[p*ROW_W+4][`CSI2_WC_W-1:0];
    cls           = rows[p*ROW_W+5];
    info.repaired = (cls == 1);
    if ((cls == 0) != (syndrome_of(raw) == '0))
    begin
      $display("input file packet %0d has class %0d, which its ECC does not fit", p, cls);
      other_errs++;
    end
    drive_word(1'b1, raw, t_edge);
    // two decoder stages and the framer register, seen at the next negedge.
    if (cls == 2)
    begin
      drop_t_q.push_back(t_edge + 3*CLK_PERIOD + CLK_PERIOD/2);
      exp_stat.dropped_cnt = exp_stat.dropped_cnt + 1'b1;
    end
    else
    begin
      hdr_q.push_back(info);
      hdr_t_q.push_back(t_edge + 3*CLK_PERIOD + CLK_PERIOD/2);
      if (cls == 1)
        exp_stat.repaired_cnt = exp_stat.repaired_cnt + 1'b1;
    end
    nbeats = (cls == 2 || info.dt < `CSI2_SHORT_DT_MAX) ? 0 : (info.wc + 3) / 4;
    for (int i = 0; i < nsend; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      drive_word(1'b1, lcg_state, t_edge);
      if (i < nbeats)
      begin
        beat.data = lcg_state;
        beat.last = (i == nbeats - 1);
        beat_q.push_back(beat);
      end
    end
    repeat (GAP_CYCLES) drive_word(1'b0, '0, t_edge);
  endtask

  always @(negedge clk)
  begin
    if (srst === 1'b0)
    begin
      if (hdr_valid)
        check_hdr(hdr);
      if (payload_valid)
        check_beat(payload);
      if (drop)
        check_drop();
    end
  end

  initial
  begin
    wait (wd_armed);
    #(wd_limit);
    $display("watchdog expired at %t, the DUT did not finish the packets", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    int cycles;
    int errs;
    $timeformat(-9, 0, " ns", 0);
    srst     = 1'b1;
    valid    = 1'b0;
    data     = '0;
    exp_stat = '0;
    $readmemh("sim/csi2_input.txt", rows);
    n_pkts = 0;
    while (n_pkts < MAX_PKTS && !$isunknown(rows[n_pkts*ROW_W]))
      n_pkts++;
    cycles = RST_CYCLES + 50;
    for (int p = 0; p < n_pkts; p++)
    begin
      cycles = cycles + 1 + int'(rows[p*ROW_W+1]) + GAP_CYCLES;
    end
    wd_limit = cycles * CLK_PERIOD * 2;
    wd_armed = 1'b1;
    if (n_pkts == 0)
    begin
      $display("input file sim/csi2_input.txt holds no packets");
      other_errs++;
    end
    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    srst = 1'b0;
    for (int p = 0; p < n_pkts; p++)
    begin
      send_packet(p);
    end
    for (int i = 0; i < 20 && (hdr_q.size() + beat_q.size() + drop_t_q.size()) != 0; i++)
    begin
      @(negedge clk);
    end
    @(negedge clk);
    check_stat(stat, exp_stat);
    if ((hdr_q.size() + beat_q.size() + drop_t_q.size()) != 0)
    begin
      $display("%0d headers, %0d payload beats and %0d drop pulses never came out",
               hdr_q.size(), beat_q.size(), drop_t_q.size());
      other_errs++;
    end
    errs = hdr_errs + beat_errs + drop_errs + stat_errs + other_errs;
    $display("errors: header %0d, beat %0d, drop %0d, stat %0d, other %0d",
             hdr_errs, beat_errs, drop_errs, stat_errs, other_errs);
    if (errs == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* files.f */
+incdir+verilog
+incdir+sim
verilog/csi2_hdr_pkg.sv
verilog/csi2_rx_pkg.sv
verilog/csi2_syndrome_rom.sv
verilog/csi2_hamming_dec.sv
verilog/csi2_pkt_framer.sv
verilog/csi2_rx_top.sv
sim/tb_csi2_rx.sv

/* sim/csi2_input.txt */
// columns: raw header, payload words to send, vc, dt, wc, class (all hex)
// class 0 clean header, 1 single-bit error that is repaired, 2 two-bit error that is dropped
1A000100 0 0 00 0001 0  // frame start
3D0005C2 0 3 02 0005 0  // line start
2000106A 4 1 2A 0010 0  // raw8 line, four full beats
3B000A9E 3 2 1E 000A 0  // yuv line, last beat partly used
2000006A 4 1 2A 0010 1  // wc bit 12 flipped
3B000A9F 3 2 1E 000A 1  // dt bit 0 flipped
3D8005C2 0 3 02 0005 1  // bit 23 flipped
1E000100 0 0 00 0001 1  // ecc bit 26 flipped
0000106A 4 1 2A 0010 1  // ecc bit 29 flipped
20000068 4 1 2A 0010 2  // bits 12 and 1 flipped, payload re-arms the decoder
2000106A 4 1 2A 0010 0  // clean again after the drop
3B000A97 3 2 1E 000A 2  // bits 3 and 0 flipped
3D0005C2 0 3 02 0005 0  // line start
